//--- rtl/rf_pkg.sv
package rf_pkg;

  // Register file geometry
  localparam int data_w = 32;
  localparam int lane_n = 4;
  localparam int reg_n  = 32;
  localparam int reg_aw = 5;

  // Instruction opcodes
  typedef enum logic [2:0] {
    op_nop  = 3'd0,
    op_add  = 3'd1,
    op_sub  = 3'd2,
    op_xor  = 3'd3,
    op_lli  = 3'd4,
    op_lui  = 3'd5,
    op_movb = 3'd6
  } opcode_e;

  // One instruction per cycle from the outside, 34 bits
  typedef struct packed {
    opcode_e           opcode;
    logic [reg_aw-1:0] rs1;
    logic [reg_aw-1:0] rs2;
    logic [reg_aw-1:0] rd;
    logic [15:0]       imm;
  } instr_t;

  // Write-back report, 42 bits
  // be and data carry the same lanes that went to the write port
  typedef struct packed {
    logic              valid;
    logic [reg_aw-1:0] rd;
    logic [lane_n-1:0] be;
    logic [data_w-1:0] data;
  } wb_t;

endpackage

//--- rtl/rf_mem_2rd_1wr.sv
`timescale 1ns/1ps

module rf_mem_2rd_1wr #(
  parameter int BITS    = 32,
  parameter int SIZE    = 32,
  parameter int WENSIZE = 4,
  parameter int FWD     = 1,
  parameter int LATENCY = 1
) (
  input  logic                    clock,

  // Read port 0
  input  logic [$clog2(SIZE)-1:0] rd_addr_0,
  input  logic                    rd_enable_0,
  output logic [BITS-1:0]         rd_dout_0,

  // Read port 1
  input  logic [$clog2(SIZE)-1:0] rd_addr_1,
  input  logic                    rd_enable_1,
  output logic [BITS-1:0]         rd_dout_1,

  // Write port 0
  input  logic [$clog2(SIZE)-1:0] wr_addr_0,
  input  logic [WENSIZE-1:0]      wr_enable_0,
  input  logic [BITS-1:0]         wr_din_0
);

  // Word seen as WENSIZE lanes, lane 0 in the low bits
  typedef logic [WENSIZE-1:0][BITS/WENSIZE-1:0] word_t;

  word_t mem [SIZE];
  word_t wr_word;

  // Both read ports share the same logic through these arrays
  logic [$clog2(SIZE)-1:0] port_addr [2];
  logic                    port_en   [2];
  logic [BITS-1:0]         port_dout [2];

  assign wr_word = wr_din_0;

  assign port_addr[0] = rd_addr_0;
  assign port_addr[1] = rd_addr_1;
  assign port_en[0]   = rd_enable_0;
  assign port_en[1]   = rd_enable_1;

  assign rd_dout_0 = port_dout[0];
  assign rd_dout_1 = port_dout[1];

  // Only the enabled lanes are written
  always_ff @(posedge clock) begin
    for (int l = 0; l < WENSIZE; l++) begin
      if (wr_enable_0[l]) begin
        mem[wr_addr_0][l] <= wr_word[l];
      end
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_rd
    logic  wr_hit;
    word_t rd_word;

    assign wr_hit = (FWD != 0) && (wr_addr_0 == port_addr[p]);

    // Array word, with any lane being written this cycle taken from the write port
    always_comb begin
      if (!port_en[p]) begin
        rd_word = 'x;
      end else begin
        rd_word = mem[port_addr[p]];
        for (int l = 0; l < WENSIZE; l++) begin
          if (wr_hit && wr_enable_0[l]) begin
            rd_word[l] = wr_word[l];
          end
        end
      end
    end

    if (LATENCY == 1) begin : g_reg
      always_ff @(posedge clock) begin
        port_dout[p] <= rd_word;
      end
    end else begin : g_comb
      assign port_dout[p] = rd_word;
    end
  end

endmodule

//--- rtl/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch
  import rf_pkg::*;
(
  input  logic              clock,
  input  logic              rst_n,

  input  logic              instr_valid,
  input  instr_t            instr,

  // Memory read requests
  output logic [reg_aw-1:0] rd_addr_0,
  output logic              rd_enable_0,
  output logic [reg_aw-1:0] rd_addr_1,
  output logic              rd_enable_1,

  // Instruction for the operand cycle
  output logic              ex_valid,
  output instr_t            ex_instr
);

  // Source usage per opcode
  function automatic logic uses_rs1(opcode_e op);
    return op inside {op_add, op_sub, op_xor, op_movb};
  endfunction

  function automatic logic uses_rs2(opcode_e op);
    return op inside {op_add, op_sub, op_xor};
  endfunction

  // Reads go out in the same cycle the instruction arrives
  assign rd_addr_0   = instr.rs1;
  assign rd_addr_1   = instr.rs2;
  assign rd_enable_0 = instr_valid && uses_rs1(instr.opcode);
  assign rd_enable_1 = instr_valid && uses_rs2(instr.opcode);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= instr_valid;
    end
  end

  // Held alongside the read data, which arrives one cycle later
  always_ff @(posedge clock) begin
    if (instr_valid) begin
      ex_instr <= instr;
    end
  end

endmodule

//--- rtl/execute_wb.sv
`timescale 1ns/1ps

module execute_wb
  import rf_pkg::*;
(
  input  logic              clock,
  input  logic              rst_n,

  input  logic              ex_valid,
  input  instr_t            ex_instr,

  // Operands from the memory read ports
  input  logic [data_w-1:0] op_a,
  input  logic [data_w-1:0] op_b,

  // Memory write port
  output logic [reg_aw-1:0] wr_addr_0,
  output logic [lane_n-1:0] wr_enable_0,
  output logic [data_w-1:0] wr_din_0,

  output wb_t               wb
);

  logic [data_w-1:0] result;
  logic [lane_n-1:0] lane_be;

  // Result already placed in its byte lanes
  always_comb begin
    result  = '0;
    lane_be = '0;
    case (ex_instr.opcode)
      op_add: begin
        result  = op_a + op_b;
        lane_be = 4'b1111;
      end
      op_sub: begin
        result  = op_a - op_b;
        lane_be = 4'b1111;
      end
      op_xor: begin
        result  = op_a ^ op_b;
        lane_be = 4'b1111;
      end
      op_lli: begin
        result  = {{(data_w/2){1'b0}}, ex_instr.imm};
        lane_be = 4'b0011;
      end
      op_lui: begin
        result  = {ex_instr.imm, {(data_w/2){1'b0}}};
        lane_be = 4'b1100;
      end
      op_movb: begin
        // Only lane 0 is enabled, upper bits are don't care
        result  = {{(data_w-8){1'b0}}, op_a[7:0]};
        lane_be = 4'b0001;
      end
      default: begin
        result  = '0;
        lane_be = '0;
      end
    endcase
  end

  // Write lands at the end of the operand cycle
  assign wr_addr_0   = ex_instr.rd;
  assign wr_enable_0 = ex_valid ? lane_be : '0;
  assign wr_din_0    = result;

  // Report mirrors the write port one cycle later
  always_ff @(posedge clock) begin
    wb.rd   <= wr_addr_0;
    wb.be   <= wr_enable_0;
    wb.data <= wr_din_0;
    if (!rst_n) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= |wr_enable_0;
    end
  end

endmodule

//--- rtl/rf_top.sv
`timescale 1ns/1ps

module rf_top
  import rf_pkg::*;
(
  input  logic   clock,
  input  logic   rst_n,

  input  logic   instr_valid,
  input  instr_t instr,

  output wb_t    wb
);

  // Fetch to memory
  logic [reg_aw-1:0] rd_addr_0;
  logic              rd_enable_0;
  logic [reg_aw-1:0] rd_addr_1;
  logic              rd_enable_1;

  // Fetch to execute
  logic              ex_valid;
  instr_t            ex_instr;

  // Memory to execute
  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;

  // Execute to memory write port
  logic [reg_aw-1:0] wr_addr_0;
  logic [lane_n-1:0] wr_enable_0;
  logic [data_w-1:0] wr_din_0;

  operand_fetch u_fetch (
    .clock       (clock),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_addr_0   (rd_addr_0),
    .rd_enable_0 (rd_enable_0),
    .rd_addr_1   (rd_addr_1),
    .rd_enable_1 (rd_enable_1),
    .ex_valid    (ex_valid),
    .ex_instr    (ex_instr)
  );

  // Forwarding covers back-to-back dependent instructions
  rf_mem_2rd_1wr #(
    .BITS    (data_w),
    .SIZE    (reg_n),
    .WENSIZE (lane_n),
    .FWD     (1),
    .LATENCY (1)
  ) u_mem (
    .clock       (clock),
    .rd_addr_0   (rd_addr_0),
    .rd_enable_0 (rd_enable_0),
    .rd_dout_0   (op_a),
    .rd_addr_1   (rd_addr_1),
    .rd_enable_1 (rd_enable_1),
    .rd_dout_1   (op_b),
    .wr_addr_0   (wr_addr_0),
    .wr_enable_0 (wr_enable_0),
    .wr_din_0    (wr_din_0)
  );

  execute_wb u_exec (
    .clock       (clock),
    .rst_n       (rst_n),
    .ex_valid    (ex_valid),
    .ex_instr    (ex_instr),
    .op_a        (op_a),
    .op_b        (op_b),
    .wr_addr_0   (wr_addr_0),
    .wr_enable_0 (wr_enable_0),
    .wr_din_0    (wr_din_0),
    .wb          (wb)
  );

endmodule

//--- sim/rf_assertions.sv
`timescale 1ns/1ps

module rf_assertions
  import rf_pkg::*;
(
  input logic clock,
  input logic rst_n,
  input wb_t  wb
);

  int failures = 0;

  // Reset clears the report by the following cycle
  valid_low_after_reset: assert property (@(posedge clock) !rst_n |=> !wb.valid)
    else begin
      $error("wb.valid was set in the cycle after reset");
      failures++;
    end

  valid_has_lanes: assert property (@(posedge clock) disable iff (!rst_n)
    wb.valid |-> (wb.be != '0))
    else begin
      $error("wb.valid was set with no byte lane enabled");
      failures++;
    end

  valid_data_known: assert property (@(posedge clock) disable iff (!rst_n)
    wb.valid |-> !$isunknown(wb.data))
    else begin
      $error("wb.data held unknown bits while wb.valid was set");
      failures++;
    end

endmodule

bind rf_top rf_assertions u_assertions (
  .clock (clock),
  .rst_n (rst_n),
  .wb    (wb)
);

//--- sim/rf_checker.sv
`timescale 1ns/1ps

module rf_checker
  import rf_pkg::*;
(
  input  logic              clock,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  instr_t            instr,
  input  logic              ref_en,
  input  logic [data_w-1:0] ref_data,
  input  wb_t               wb,
  output int                error_count,
  output int                check_count
);

  // One predicted report per sampled cycle
  typedef struct packed {
    logic              write;
    logic              has_ref;
    logic [reg_aw-1:0] rd;
    logic [lane_n-1:0] be;
    logic [data_w-1:0] data;
    logic [data_w-1:0] ref_data;
  } expect_t;

  logic [data_w-1:0] model [reg_n];
  expect_t           pending [$];
  int                errors = 0;
  int                checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  task automatic compare(input expect_t e);
    logic [data_w-1:0] mask;
    for (int l = 0; l < lane_n; l++) begin
      mask[8*l +: 8] = {8{e.be[l]}};
    end
    if (wb.valid !== e.write) begin
      $display("[ERROR] %0t: wb.valid expected %0b, got %0b", $time, e.write, wb.valid);
      errors++;
    end else if (e.write) begin
      checks++;
      if (wb.rd !== e.rd) begin
        $display("[ERROR] %0t: wb.rd expected %0d, got %0d", $time, e.rd, wb.rd);
        errors++;
      end
      if (wb.be !== e.be) begin
        $display("[ERROR] %0t: wb.be expected %b, got %b", $time, e.be, wb.be);
        errors++;
      end
      if ((wb.data & mask) !== (e.data & mask)) begin
        $display("[ERROR] %0t: wb.data expected %h, got %h (lanes %b)",
                 $time, e.data & mask, wb.data & mask, e.be);
        errors++;
      end
      // Hand-computed table value, same lanes
      if (e.has_ref && ((wb.data & mask) !== (e.ref_data & mask))) begin
        $display("[ERROR] %0t: wb.data differs from table value %h, got %h",
                 $time, e.ref_data & mask, wb.data & mask);
        errors++;
      end
    end
  endtask

  always @(posedge clock) begin : watch
    expect_t           due;
    expect_t           next;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    if (!rst_n) begin
      pending.delete();
    end else begin
      // Report for the instruction sampled two edges ago
      if (pending.size() == 2) begin
        due = pending.pop_front();
        compare(due);
      end else if (wb.valid !== 1'b0) begin
        $display("[ERROR] %0t: wb.valid set with no instruction in flight", $time);
        errors++;
      end

      a    = model[instr.rs1];
      b    = model[instr.rs2];
      next = '0;
      next.rd       = instr.rd;
      next.has_ref  = ref_en;
      next.ref_data = ref_data;
      case (instr.opcode)
        op_add: begin
          next.be   = 4'b1111;
          next.data = a + b;
        end
        op_sub: begin
          next.be   = 4'b1111;
          next.data = a - b;
        end
        op_xor: begin
          next.be   = 4'b1111;
          next.data = a ^ b;
        end
        op_lli: begin
          next.be   = 4'b0011;
          next.data = {16'h0000, instr.imm};
        end
        op_lui: begin
          next.be   = 4'b1100;
          next.data = {instr.imm, 16'h0000};
        end
        op_movb: begin
          next.be   = 4'b0001;
          next.data = {24'h000000, a[7:0]};
        end
        default: next.be = '0;
      endcase
      if (!instr_valid) begin
        next.be = '0;
      end
      next.write = |next.be;

      // Merge now, the next instruction already sees this write
      for (int l = 0; l < lane_n; l++) begin
        if (next.be[l]) begin
          model[instr.rd][8*l +: 8] = next.data[8*l +: 8];
        end
      end
      pending.push_back(next);
    end
  end

endmodule

//--- sim/tb_rf.sv
`timescale 1ns/1ps

module tb_rf;
  import rf_pkg::*;

  localparam int rand_n = 200;

  typedef struct packed {
    instr_t            instr;
    logic              has_ref;
    logic [data_w-1:0] ref_data;
  } stim_row_t;

  logic              clock;
  logic              rst_n;
  logic              instr_valid;
  instr_t            instr;
  logic              ref_en;
  logic [data_w-1:0] ref_data;
  wb_t               wb;
  int                error_count;
  int                check_count;

  stim_row_t         stim_table [$];
  // Lanes of each register written so far by the stimulus
  logic [lane_n-1:0] lanes_init [reg_n];

  rf_top dut0 (
    .clock       (clock),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb)
  );

  rf_checker check0 (
    .clock       (clock),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ref_en      (ref_en),
    .ref_data    (ref_data),
    .wb          (wb),
    .error_count (error_count),
    .check_count (check_count)
  );

  always #4 clock = ~clock;

  function automatic void add_row(opcode_e op,
                                  logic [reg_aw-1:0] rs1,
                                  logic [reg_aw-1:0] rs2,
                                  logic [reg_aw-1:0] rd,
                                  logic [15:0] imm,
                                  logic [data_w-1:0] exp_data);
    stim_row_t row;
    row.instr.opcode = op;
    row.instr.rs1    = rs1;
    row.instr.rs2    = rs2;
    row.instr.rd     = rd;
    row.instr.imm    = imm;
    row.has_ref      = (op != op_nop);
    row.ref_data     = exp_data;
    stim_table.push_back(row);
  endfunction

  function automatic logic [lane_n-1:0] lanes_written(opcode_e op);
    case (op)
      op_add, op_sub, op_xor: return 4'b1111;
      op_lli:                 return 4'b0011;
      op_lui:                 return 4'b1100;
      op_movb:                return 4'b0001;
      default:                return 4'b0000;
    endcase
  endfunction

  // Random source among fully written registers
  function automatic logic [reg_aw-1:0] pick_source();
    logic [reg_aw-1:0] r;
    r = reg_aw'($urandom_range(reg_n - 1, 0));
    while (lanes_init[r] != 4'hf) begin
      r = reg_aw'($urandom_range(reg_n - 1, 0));
    end
    return r;
  endfunction

  initial begin
    void'($urandom(32'hb7b9));
    clock       = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    ref_en      = 1'b0;
    ref_data    = '0;
    foreach (lanes_init[r]) begin
      lanes_init[r] = '0;
    end

    // op, rs1, rs2, rd, imm, expected data on the written lanes
    add_row(op_nop,  0, 0,  0, 16'h0000, 32'h0000_0000);
    add_row(op_lli,  0, 0,  1, 16'h5678, 32'h0000_5678);
    add_row(op_lui,  0, 0,  1, 16'h1234, 32'h1234_0000);
    add_row(op_lli,  0, 0,  2, 16'h0001, 32'h0000_0001);
    add_row(op_lui,  0, 0,  2, 16'h0010, 32'h0010_0000);
    add_row(op_add,  1, 2,  3, 16'h0000, 32'h1244_5679);
    add_row(op_nop,  0, 0,  3, 16'h0000, 32'h0000_0000);
    add_row(op_sub,  3, 1,  4, 16'h0000, 32'h0010_0001);
    add_row(op_xor,  4, 1,  5, 16'h0000, 32'h1224_5679);
    add_row(op_add,  5, 5,  5, 16'h0000, 32'h2448_acf2);
    add_row(op_movb, 1, 0,  5, 16'h0000, 32'h0000_0078);
    add_row(op_add,  5, 2,  6, 16'h0000, 32'h2458_ac79);
    add_row(op_lui,  0, 0,  6, 16'hbeef, 32'hbeef_0000);
    add_row(op_xor,  6, 1,  7, 16'h0000, 32'hacdb_fa01);
    add_row(op_nop,  7, 7,  7, 16'h0000, 32'h0000_0000);
    add_row(op_sub,  1, 7,  8, 16'h0000, 32'h6558_5c77);
    add_row(op_movb, 8, 0,  9, 16'h0000, 32'h0000_0077);
    add_row(op_lli,  0, 0,  9, 16'hcafe, 32'h0000_cafe);
    add_row(op_lui,  0, 0,  9, 16'h0bad, 32'h0bad_0000);
    add_row(op_add,  9, 9, 10, 16'h0000, 32'h175b_95fc);

    repeat (2) @(posedge clock);
    rst_n <= 1'b1;

    foreach (stim_table[i]) begin
      @(posedge clock);
      instr_valid <= 1'b1;
      instr       <= stim_table[i].instr;
      ref_en      <= stim_table[i].has_ref;
      ref_data    <= stim_table[i].ref_data;
      lanes_init[stim_table[i].instr.rd] |= lanes_written(stim_table[i].instr.opcode);
    end

    // Random mix with occasional idle cycles
    for (int n = 0; n < rand_n; n++) begin
      instr_t ri;
      logic   issue;
      issue     = ($urandom_range(7, 0) != 0);
      ri.opcode = opcode_e'($urandom_range(6, 0));
      ri.rs1    = pick_source();
      ri.rs2    = pick_source();
      ri.rd     = reg_aw'($urandom_range(reg_n - 1, 0));
      ri.imm    = 16'($urandom());
      if (issue) begin
        lanes_init[ri.rd] |= lanes_written(ri.opcode);
      end
      @(posedge clock);
      instr_valid <= issue;
      instr       <= ri;
      ref_en      <= 1'b0;
    end

    @(posedge clock);
    instr_valid <= 1'b0;
    ref_en      <= 1'b0;
    // Pipeline depth is two cycles
    repeat (3) @(posedge clock);
    @(negedge clock);

    $display("write-backs checked %0d, compare errors %0d, assertion errors %0d",
             check_count, error_count, dut0.u_assertions.failures);
    if (error_count == 0 && dut0.u_assertions.failures == 0 && check_count > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #1;
    repeat (stim_table.size() + rand_n + 20) @(posedge clock);
    $display("timeout: the run did not finish within %0d cycles",
             stim_table.size() + rand_n + 20);
    $display("sim failed");
    $finish;
  end

endmodule

//--- flist.f
rtl/rf_pkg.sv
rtl/rf_mem_2rd_1wr.sv
rtl/operand_fetch.sv
rtl/execute_wb.sv
rtl/rf_top.sv
sim/rf_assertions.sv
sim/rf_checker.sv
sim/tb_rf.sv

//--- Bender.yml
package:
  name: rf_subsystem

sources:
  - files:
      - rtl/rf_pkg.sv
      - rtl/rf_mem_2rd_1wr.sv
      - rtl/operand_fetch.sv
      - rtl/execute_wb.sv
      - rtl/rf_top.sv

  - target: simulation
    files:
      - sim/rf_assertions.sv
      - sim/rf_checker.sv
      - sim/tb_rf.sv
